//--- hw/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// base sizes
`define CACHE_ADDR_W 32
`define CACHE_INDEX_W 6
`define CACHE_WORD_W 32
`define CACHE_WORDS 4
`define CACHE_WAYS 2

// ----------------------------------------------------------------------
// derived sizes
`define CACHE_SETS (1 << `CACHE_INDEX_W)
`define CACHE_WSEL_W $clog2(`CACHE_WORDS)
`define CACHE_OFFSET_W (`CACHE_WSEL_W + $clog2(`CACHE_WORD_W / 8)) // byte offset in a line
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)
`define CACHE_LINE_W (`CACHE_WORDS * `CACHE_WORD_W)

// tag and index together, the line address on the memory bus
`define CACHE_LADDR_W (`CACHE_TAG_W + `CACHE_INDEX_W)

`endif

//--- hw/cachePkg.sv
`include "cache_settings.svh"

package cachePkg;

	typedef logic [`CACHE_ADDR_W-1:0] addrT;
	typedef logic [`CACHE_TAG_W-1:0] tagT;
	typedef logic [`CACHE_INDEX_W-1:0] indexT;
	typedef logic [`CACHE_WSEL_W-1:0] wordSelT;
	typedef logic [`CACHE_WORD_W-1:0] wordT;
	typedef logic [`CACHE_LINE_W-1:0] lineT; // word 0 in the low bits
	typedef logic [`CACHE_WAYS-1:0] wayMaskT;

	typedef enum logic [1:0] {opRead, opWrite, opInvalidate} cacheOpT;

	typedef enum logic [2:0] {sIdle, sLookup, sWriteBack, sFill, sRespond} ctrlStateT;

	typedef struct packed {
		cacheOpT op;
		addrT addr;
		wordT wdata;
	} cacheReqT;

	typedef struct packed {
		logic write;
		logic [`CACHE_LADDR_W-1:0] lineAddr;
		lineT line;
	} memReqT;

	// ----------------------------------------------------------------------
	// controller to ways, and back
	typedef struct packed {
		indexT index;
		wordSelT wordSel;
		tagT tag;
		lineT fillLine;
		wordT wdata;
		logic fill;
		logic writeWord;
		logic clean;
		logic invalidate;
	} wayCmdT;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
		tagT tag;
		lineT line;
	} wayStatusT;

endpackage

//--- hw/cacheWay.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheWay import cachePkg::*; (
	input logic clk,
	input logic reset,
	input wayCmdT cmd,
	input logic sel,
	output wayStatusT status
);

	tagT tagMem [`CACHE_SETS];
	lineT dataMem [`CACHE_SETS];
	logic [`CACHE_SETS-1:0] validBits;
	logic [`CACHE_SETS-1:0] dirtyBits;
	lineT storedLine;
	lineT nextLine;

	assign storedLine = dataMem[cmd.index];

	// ----------------------------------------------------------------------
	// lookup at the commanded index
	always_comb begin
		status.valid = validBits[cmd.index];
		status.dirty = dirtyBits[cmd.index];
		status.tag = tagMem[cmd.index];
		status.line = storedLine;
		status.hit = validBits[cmd.index] && (tagMem[cmd.index] == cmd.tag);
	end

	// fill line or stored line, with the word merged on top
	always_comb begin
		nextLine = cmd.fill ? cmd.fillLine : storedLine;
		if (cmd.writeWord) begin
			nextLine[cmd.wordSel * `CACHE_WORD_W +: `CACHE_WORD_W] = cmd.wdata;
		end
	end

	// ----------------------------------------------------------------------
	// state bits
	always_ff @(posedge clk) begin
		if (reset) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else if (sel) begin
			if (cmd.fill) begin
				validBits[cmd.index] <= 1'b1;
				dirtyBits[cmd.index] <= cmd.writeWord; // write miss leaves it dirty
			end else if (cmd.writeWord) begin
				dirtyBits[cmd.index] <= 1'b1;
			end
			if (cmd.clean) begin
				dirtyBits[cmd.index] <= 1'b0; // line now matches memory
			end
			if (cmd.invalidate) begin
				validBits[cmd.index] <= 1'b0;
				dirtyBits[cmd.index] <= 1'b0;
			end
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (sel && (cmd.fill || cmd.writeWord)) begin
			dataMem[cmd.index] <= nextLine;
		end
		if (sel && cmd.fill) begin
			tagMem[cmd.index] <= cmd.tag;
		end
	end

endmodule

//--- hw/wayResolver.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module wayResolver import cachePkg::*; (
	input logic clk,
	input logic reset,
	input wayStatusT status [`CACHE_WAYS],
	input wayCmdT cmd,
	input logic touch,
	input wayMaskT touchMask,
	output logic hitAny,
	output wayMaskT hitMask,
	output wayMaskT victimMask,
	output logic victimDirty,
	output tagT victimTag,
	output lineT victimLine,
	output wordT rdata
);

	logic [`CACHE_SETS-1:0] lruBits; // number of the least recently used way
	logic lruWay;
	logic pickWay;

	assign lruWay = lruBits[cmd.index];

	always_comb begin
		hitMask = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hitMask[w] = status[w].hit;
		end
		victimMask = '0;
		victimMask[lruWay] = 1'b1;
	end

	assign hitAny = |hitMask;

	// ----------------------------------------------------------------------
	// hit way first, so an invalidate sees the line it hit
	assign pickWay = hitMask[1] ? 1'b1 : (hitMask[0] ? 1'b0 : lruWay);

	assign victimDirty = status[pickWay].valid && status[pickWay].dirty;
	assign victimTag = status[pickWay].tag;
	assign victimLine = status[pickWay].line;
	assign rdata = status[pickWay].line[cmd.wordSel * `CACHE_WORD_W +: `CACHE_WORD_W];

	// LRU table
	always_ff @(posedge clk) begin
		if (reset) begin
			lruBits <= '0;
		end else if (touch) begin
			lruBits[cmd.index] <= touchMask[0]; // way 0 used, way 1 goes next
		end
	end

endmodule

//--- hw/missController.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module missController import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input cacheReqT req,
	output logic reqReady,
	output logic respValid,
	input logic hitAny,
	input wayMaskT hitMask,
	input wayMaskT victimMask,
	input logic victimDirty,
	input tagT victimTag,
	input lineT victimLine,
	output wayCmdT cmd,
	output wayMaskT sel,
	output logic touch,
	output wayMaskT touchMask,
	output logic memReqValid,
	output memReqT memReq,
	input logic memReqReady,
	input logic memRespValid,
	input lineT memResp
);

	ctrlStateT state;
	cacheReqT reqQ;
	wayMaskT targetMask; // picked at lookup, kept through write-back and fill
	tagT reqTag;
	indexT reqIndex;
	logic isInval;
	logic isWrite;
	logic toWriteBack;
	logic memAccept;

	assign reqTag = reqQ.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	assign reqIndex = reqQ.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign isInval = (reqQ.op == opInvalidate);
	assign isWrite = (reqQ.op == opWrite);
	assign memAccept = memReqValid && memReqReady;

	// dirty hit for invalidate, dirty victim for a miss
	assign toWriteBack = victimDirty && (isInval ? hitAny : !hitAny);

	assign reqReady = (state == sIdle);
	assign respValid = (state == sRespond);

	// ----------------------------------------------------------------------
	// way commands
	always_comb begin
		cmd.index = reqIndex;
		cmd.wordSel = reqQ.addr[`CACHE_OFFSET_W-1 -: `CACHE_WSEL_W];
		cmd.tag = reqTag;
		cmd.fillLine = memResp;
		cmd.wdata = reqQ.wdata;
		cmd.fill = 1'b0;
		cmd.writeWord = 1'b0;
		cmd.clean = 1'b0;
		cmd.invalidate = 1'b0;
		sel = '0;
		touch = 1'b0;
		touchMask = '0;
		case (state)
			sLookup: begin
				if (hitAny && !isInval) begin
					cmd.writeWord = isWrite;
					sel = hitMask;
					touch = 1'b1;
					touchMask = hitMask;
				end else if (hitAny && !victimDirty) begin
					cmd.invalidate = 1'b1; // clean line, nothing to flush
					sel = hitMask;
				end
			end
			sWriteBack: begin
				if (memAccept) begin
					cmd.invalidate = isInval;
					cmd.clean = !isInval;
					sel = targetMask;
				end
			end
			sFill: begin
				if (memRespValid) begin
					cmd.fill = 1'b1;
					cmd.writeWord = isWrite; // write-allocate merge
					sel = targetMask;
					touch = 1'b1;
					touchMask = targetMask;
				end
			end
			default: ;
		endcase
	end

	// ----------------------------------------------------------------------
	// FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sIdle;
			memReqValid <= 1'b0;
		end else begin
			case (state)
				sIdle: begin
					if (reqValid) begin
						state <= sLookup;
					end
				end
				sLookup: begin
					if (hitAny && !isInval) begin
						state <= sRespond;
					end else if (toWriteBack) begin
						memReqValid <= 1'b1;
						state <= sWriteBack;
					end else if (isInval) begin
						state <= sRespond;
					end else begin
						memReqValid <= 1'b1;
						state <= sFill;
					end
				end
				sWriteBack: begin
					if (memAccept) begin
						memReqValid <= !isInval; // fill request follows at once
						state <= isInval ? sRespond : sFill;
					end
				end
				sFill: begin
					if (memAccept) begin
						memReqValid <= 1'b0;
					end
					if (memRespValid) begin
						state <= sRespond;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// request, target way and memory payload
	always_ff @(posedge clk) begin
		if (reqValid && reqReady) begin
			reqQ <= req;
		end
		if (state == sLookup) begin
			targetMask <= isInval ? hitMask : victimMask;
			memReq.write <= toWriteBack;
			memReq.lineAddr <= toWriteBack ? {victimTag, reqIndex} : {reqTag, reqIndex};
			memReq.line <= victimLine;
		end else if (state == sWriteBack && memAccept) begin
			memReq.write <= 1'b0;
			memReq.lineAddr <= {reqTag, reqIndex};
		end
	end

endmodule

//--- hw/setAssocCache.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module setAssocCache import cachePkg::*; (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input cacheReqT req,
	output logic reqReady,
	output logic respValid,
	output wordT rdata,
	output logic memReqValid,
	output memReqT memReq,
	input logic memReqReady,
	input logic memRespValid,
	input lineT memResp
);

	wayCmdT cmd;
	wayMaskT sel;
	wayStatusT wayStatus [`CACHE_WAYS];
	logic touch;
	wayMaskT touchMask;
	logic hitAny;
	wayMaskT hitMask;
	wayMaskT victimMask;
	logic victimDirty;
	tagT victimTag;
	lineT victimLine;

	missController controller (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.reqReady(reqReady),
		.respValid(respValid),
		.hitAny(hitAny),
		.hitMask(hitMask),
		.victimMask(victimMask),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.victimLine(victimLine),
		.cmd(cmd),
		.sel(sel),
		.touch(touch),
		.touchMask(touchMask),
		.memReqValid(memReqValid),
		.memReq(memReq),
		.memReqReady(memReqReady),
		.memRespValid(memRespValid),
		.memResp(memResp)
	);

	// ----------------------------------------------------------------------
	// ways, all fed the same command
	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : gWay
		cacheWay way (
			.clk(clk),
			.reset(reset),
			.cmd(cmd),
			.sel(sel[w]),
			.status(wayStatus[w])
		);
	end

	wayResolver resolver (
		.clk(clk),
		.reset(reset),
		.status(wayStatus),
		.cmd(cmd),
		.touch(touch),
		.touchMask(touchMask),
		.hitAny(hitAny),
		.hitMask(hitMask),
		.victimMask(victimMask),
		.victimDirty(victimDirty),
		.victimTag(victimTag),
		.victimLine(victimLine),
		.rdata(rdata)
	);

endmodule

//--- tests/cacheMemModel.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheMemModel import cachePkg::*; #(
	parameter wordT fillBase = 32'h0
) (
	input logic clk,
	input logic reset,
	input logic memReqValid,
	input memReqT memReq,
	output logic memReqReady,
	output logic memRespValid,
	output lineT memResp,
	output int readCount,
	output int writeCount,
	output logic [`CACHE_LADDR_W-1:0] lastWbAddr,
	output lineT lastWbLine
);

	lineT lines [logic [`CACHE_LADDR_W-1:0]]; // only lines written back
	memReqT accepted;
	lineT respLine;
	integer seed;
	int stallLeft;
	int respLeft;

	function automatic int randBelow(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// untouched lines follow the fill rule, word address plus base
	function automatic lineT readLine(input logic [`CACHE_LADDR_W-1:0] lineAddr);
		lineT line;
		if (lines.exists(lineAddr)) begin
			return lines[lineAddr];
		end
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = {2'b00, lineAddr, w[1:0]} + fillBase;
		end
		return line;
	endfunction

	// ----------------------------------------------------------------------
	// transfers recorded on the handshake edge, bus driven 1 ns after it
	initial begin
		seed = 45715;
		memReqReady = 1'b0;
		memRespValid = 1'b0;
		memResp = '0;
		readCount = 0;
		writeCount = 0;
		lastWbAddr = '0;
		lastWbLine = '0;
		stallLeft = -1;
		respLeft = 0;
		forever begin
			@(posedge clk);
			if (!reset && memReqReady) begin
				if (accepted.write) begin
					lines[accepted.lineAddr] = accepted.line;
					writeCount++;
					lastWbAddr = accepted.lineAddr;
					lastWbLine = accepted.line;
				end else begin
					readCount++;
					respLine = readLine(accepted.lineAddr);
					respLeft = 1 + randBelow(4); // cycles to the response
				end
			end
			#1;
			memRespValid = 1'b0;
			if (reset) begin
				memReqReady = 1'b0;
				stallLeft = -1;
				respLeft = 0;
			end else begin
				if (respLeft > 0) begin
					respLeft--;
					if (respLeft == 0) begin
						memRespValid = 1'b1;
						memResp = respLine;
					end
				end
				if (memReqReady) begin
					memReqReady = 1'b0; // handshake on the edge just passed
				end else if (memReqValid) begin
					if (stallLeft < 0) begin
						stallLeft = randBelow(4);
					end
					if (stallLeft == 0) begin
						memReqReady = 1'b1;
						accepted = memReq; // held stable until accepted
					end
					stallLeft--;
				end
			end
		end
	end

endmodule

//--- tests/cacheTb.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cacheTb import cachePkg::*; ();

	localparam wordT fillBase = 32'h5EED_0000;
	localparam int randomOps = 300;
	localparam int maxReqCycles = 40;
	localparam int timeoutCycles = (randomOps + 100) * maxReqCycles + 4000; // 20000

	logic clk;
	logic reset;
	logic reqValid;
	cacheReqT req;
	logic reqReady;
	logic respValid;
	wordT rdata;
	logic memReqValid;
	memReqT memReq;
	logic memReqReady;
	logic memRespValid;
	lineT memResp;
	int readCount;
	int writeCount;
	logic [`CACHE_LADDR_W-1:0] lastWbAddr;
	lineT lastWbLine;
	wordT golden [logic [`CACHE_ADDR_W-3:0]]; // by word address, written words only
	integer seed;
	int cycleCount = 0;

	setAssocCache dut_i (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.reqReady(reqReady),
		.respValid(respValid),
		.rdata(rdata),
		.memReqValid(memReqValid),
		.memReq(memReq),
		.memReqReady(memReqReady),
		.memRespValid(memRespValid),
		.memResp(memResp)
	);

	cacheMemModel #(.fillBase(fillBase)) mem_i (
		.clk(clk),
		.reset(reset),
		.memReqValid(memReqValid),
		.memReq(memReq),
		.memReqReady(memReqReady),
		.memRespValid(memRespValid),
		.memResp(memResp),
		.readCount(readCount),
		.writeCount(writeCount),
		.lastWbAddr(lastWbAddr),
		.lastWbLine(lastWbLine)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: run still busy after %0d cycles", timeoutCycles);
			abortRun();
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	task automatic abortRun();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkWord(input string test, input wordT expected, input wordT actual);
		assert (actual === expected) else begin
			$display("ERR %s: expected %h, actual %h", test, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkLine(input string test, input lineT expected, input lineT actual);
		assert (actual === expected) else begin
			$display("ERR %s: expected %h, actual %h", test, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkCount(input string test, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("ERR %s: expected %0d, actual %0d", test, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkTraffic(input string test, input int reads, input int writes);
		checkCount(test, reads, readCount);
		checkCount(test, writes, writeCount);
	endtask

	function automatic addrT makeAddr(input tagT tag, input indexT index, input wordSelT sel);
		return {tag, index, sel, 2'b00};
	endfunction

	function automatic wordT goldenWord(input addrT addr);
		if (golden.exists(addr[`CACHE_ADDR_W-1:2])) begin
			return golden[addr[`CACHE_ADDR_W-1:2]];
		end
		return {2'b00, addr[`CACHE_ADDR_W-1:2]} + fillBase;
	endfunction

	function automatic lineT goldenLine(input tagT tag, input indexT index);
		lineT line;
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = goldenWord(makeAddr(tag, index, w[1:0]));
		end
		return line;
	endfunction

	// edges counts from the accepting edge to the edge that samples respValid
	task automatic issueRequest(input cacheOpT op, input addrT addr, input wordT wdata,
			output wordT data, output int edges);
		@(posedge clk);
		#1;
		req.op = op;
		req.addr = addr;
		req.wdata = wdata;
		reqValid = 1'b1;
		while (!reqReady) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // accepted here
		#1;
		reqValid = 1'b0;
		if (op == opWrite) begin
			golden[addr[`CACHE_ADDR_W-1:2]] = wdata;
		end
		edges = 1;
		while (!respValid) begin
			@(posedge clk);
			#1;
			edges++;
		end
		data = rdata;
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	task automatic readMissThenHit();
		string test;
		wordT data;
		int edges, reads, writes;
		test = "readMissThenHit";
		reads = readCount;
		writes = writeCount;
		issueRequest(opRead, makeAddr(22'h00011, 6'd5, 2'd2), '0, data, edges);
		checkWord(test, goldenWord(makeAddr(22'h00011, 6'd5, 2'd2)), data);
		checkTraffic(test, reads + 1, writes);
		issueRequest(opRead, makeAddr(22'h00011, 6'd5, 2'd1), '0, data, edges);
		checkWord(test, goldenWord(makeAddr(22'h00011, 6'd5, 2'd1)), data);
		checkTraffic(test, reads + 1, writes);
		checkCount(test, 2, edges); // hit latency
	endtask

	task automatic writeHit();
		string test;
		wordT data;
		int edges, reads, writes;
		test = "writeHit";
		reads = readCount;
		writes = writeCount;
		issueRequest(opWrite, makeAddr(22'h00011, 6'd5, 2'd1), 32'hCAFE_0001, data, edges);
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			issueRequest(opRead, makeAddr(22'h00011, 6'd5, w[1:0]), '0, data, edges);
			checkWord(test, goldenWord(makeAddr(22'h00011, 6'd5, w[1:0])), data);
		end
		checkTraffic(test, reads, writes);
	endtask

	task automatic lruWriteBack();
		string test;
		addrT a;
		wordT data;
		int edges, reads, writes;
		test = "lruWriteBack";
		a = makeAddr(22'h00100, 6'd9, 2'd0);
		issueRequest(opRead, a, '0, data, edges);
		issueRequest(opWrite, makeAddr(22'h00200, 6'd9, 2'd3), 32'hB0B0_0003, data, edges);
		issueRequest(opRead, a, '0, data, edges); // B becomes LRU
		reads = readCount;
		writes = writeCount;
		issueRequest(opRead, makeAddr(22'h00300, 6'd9, 2'd2), '0, data, edges);
		checkWord(test, goldenWord(makeAddr(22'h00300, 6'd9, 2'd2)), data);
		checkTraffic(test, reads + 1, writes + 1);
		checkWord(test, {4'h0, 22'h00200, 6'd9}, {4'h0, lastWbAddr});
		checkLine(test, goldenLine(22'h00200, 6'd9), lastWbLine);
		issueRequest(opRead, a, '0, data, edges);
		checkWord(test, goldenWord(a), data);
		checkTraffic(test, reads + 1, writes + 1);
		checkCount(test, 2, edges);
	endtask

	task automatic invalidateLines();
		string test;
		addrT addr;
		wordT data;
		int edges, reads, writes;
		test = "invalidateLines";
		addr = makeAddr(22'h00011, 6'd5, 2'd1); // dirty since writeHit
		reads = readCount;
		writes = writeCount;
		issueRequest(opInvalidate, addr, '0, data, edges);
		checkTraffic(test, reads, writes + 1);
		checkWord(test, {4'h0, 22'h00011, 6'd5}, {4'h0, lastWbAddr});
		checkLine(test, goldenLine(22'h00011, 6'd5), lastWbLine);
		issueRequest(opRead, addr, '0, data, edges);
		checkWord(test, goldenWord(addr), data);
		checkTraffic(test, reads + 1, writes + 1);
		// clean line, then a line that is not cached
		issueRequest(opInvalidate, addr, '0, data, edges);
		issueRequest(opInvalidate, makeAddr(22'h3FFFF, 6'd5, 2'd0), '0, data, edges);
		checkTraffic(test, reads + 1, writes + 1);
		issueRequest(opRead, addr, '0, data, edges);
		checkWord(test, goldenWord(addr), data);
		checkTraffic(test, reads + 2, writes + 1);
	endtask

	task automatic randomMix();
		string test;
		wordT bits, wdata, data;
		addrT addr;
		int edges;
		test = "randomMix";
		for (int i = 0; i < randomOps; i++) begin
			bits = $random(seed);
			wdata = $random(seed);
			addr = makeAddr({19'h00040, bits[2:0]}, {4'h2, bits[4:3]}, bits[6:5]);
			if (bits[7]) begin
				issueRequest(opWrite, addr, wdata, data, edges);
			end else begin
				issueRequest(opRead, addr, '0, data, edges);
				checkWord(test, goldenWord(addr), data);
			end
		end
	endtask

	// ----------------------------------------------------------------------
	initial begin
		seed = 45715;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		checkWord("afterReset", 32'h1, {31'b0, reqReady});
		checkWord("afterReset", 32'h0, {30'b0, respValid, memReqValid});
		readMissThenHit();
		writeHit();
		lruWriteBack();
		invalidateLines();
		randomMix();
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- src.f
+incdir+hw
hw/cachePkg.sv
hw/cacheWay.sv
hw/wayResolver.sv
hw/missController.sv
hw/setAssocCache.sv
tests/cacheMemModel.sv
tests/cacheTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cacheTb
LINT_TOP ?= setAssocCache
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS ?= hw/cachePkg.sv hw/cacheWay.sv hw/wayResolver.sv hw/missController.sv \
	hw/setAssocCache.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard hw/*.sv hw/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+hw --top-module $(LINT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
